//--- build.f
+incdir+tests
design/sd_pkg.sv
design/sd_clk_divider.sv
design/sd_cmd_framer.sv
design/sd_frame_fifo.sv
design/sd_cmd_serializer.sv
design/sd_cmd_host.sv
tests/tb_sd_cmd_host.sv

//--- Makefile
# Verilator build and run for the SD command path testbench
VERILATOR ?= verilator
TOP       ?= tb_sd_cmd_host
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_sd_crc7.svh
/*
  Reference frame builder for the testbench.
  CRC7 by polynomial long division of M(x)*x^7 by x^7+x^3+1 (0x89).
  Needs the sd_pkg types visible where it is included.
*/

`ifndef TB_SD_CRC7_SVH
`define TB_SD_CRC7_SVH

// remainder of the 40 leading bits, divided msb first
function automatic crc7_t ref_crc7(input logic [39:0] lead);
  logic [46:0] r;   // message with 7 zero bits appended
  int          i;
  r = {lead, 7'b0};
  for (i = 46; i >= 7; i--) begin
    if (r[i]) r[i -: 8] = r[i -: 8] ^ 8'h89;  // subtract the generator
  end
  return r[6:0];
endfunction

// start 0, tx 1, index, arg, crc7, end 1
function automatic sd_frame_t build_frame(input cmd_index_t idx, input cmd_arg_t arg);
  logic [39:0] lead;
  lead = {1'b0, 1'b1, idx, arg};
  return {lead, ref_crc7(lead), 1'b1};
endfunction

`endif

//--- tests/tb_sd_cmd_host.sv
/*
  Directed testbench for sd_cmd_host.
  Frames are rebuilt from CMD at sd_clk rising edges, seen at i_clk falls.
  Divide values stay small so the watchdog limit stays short.
*/

`timescale 1ns/1ps

module tb_sd_cmd_host;

  import sd_pkg::*;
  `include "tb_sd_crc7.svh"

  localparam int DIV_WIDTH  = 8;
  localparam int FIFO_DEPTH = 4;
  localparam int N_FRAMES   = 13;  // 1 + 4 + 6 + 2
  localparam int MAX_DIV    = 5;
  localparam int LIMIT      = N_FRAMES * (48 * 2 * (MAX_DIV + 1) + 60) + 3000;

  logic                 clk;
  logic                 rst_n;
  logic                 cmd_strobe;
  sd_cmd_t              cmd_in;
  logic [DIV_WIDTH-1:0] div_max;
  logic                 div_en;
  logic                 sd_clk;
  logic                 sd_cmd_o;
  logic                 busy;
  logic                 cmd_done;

  logic [31:0]    lfsr = 32'h78ae_b832;
  int             errors = 0;
  int             checks = 0;
  int             cycles = 0;
  int             issued = 0;    // commands strobed
  int             checked = 0;   // frames compared so far
  int             frames_seen = 0;
  int             done_cnt = 0;
  int             nbits = 0;     // bits of the frame on the line
  logic           prev_clk = 1'b0;
  sd_frame_t      rx;
  sd_frame_t      got_mem [32];  // frames as the monitor rebuilt them
  sd_frame_t      exp_q [$];     // expected frames in issue order

  sd_cmd_host #(.DIV_WIDTH(DIV_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) dut0 (
    .i_clk(clk), .i_rst_n(rst_n), .i_cmd_strobe(cmd_strobe), .i_cmd(cmd_in),
    .i_div_max(div_max), .i_div_en(div_en), .o_sd_clk(sd_clk),
    .o_sd_cmd(sd_cmd_o), .o_busy(busy), .o_cmd_done(cmd_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 20 ns
  end

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: DUT did not finish within %0d cycles", LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // CMD monitor, rising sd_clk or every cycle in bypass
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      if (cmd_done) done_cnt++;
      if (!div_en || (sd_clk && !prev_clk)) begin
        if (nbits > 0 || sd_cmd_o === 1'b0) begin   // start bit opens a frame
          rx = {rx[46:0], sd_cmd_o};
          nbits++;
          if (nbits == SD_FRAME_BITS) begin
            got_mem[frames_seen] = rx;
            frames_seen++;
            nbits = 0;
          end
        end
      end
      prev_clk = sd_clk;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_frame(input sd_frame_t got, input sd_frame_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_period(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[FAIL] %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[FAIL] %0t: %s count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic sd_cmd_t rand_cmd();
    sd_cmd_t c;
    c.index = cmd_index_t'(take_bits(6));
    c.arg   = take_bits(32);
    return c;
  endfunction

  task automatic issue_cmd(input sd_cmd_t c, input sd_frame_t exp);
    do @(negedge clk); while (busy);   // framer back in IDLE
    @(posedge clk);
    cmd_strobe <= 1'b1;
    cmd_in     <= c;
    @(posedge clk);
    cmd_strobe <= 1'b0;
    exp_q.push_back(exp);
    issued++;
  endtask

  // compare frames as they land, then wait out the tail
  task automatic drain_frames();
    do begin
      @(negedge clk);
      while (checked < frames_seen && exp_q.size() > 0) begin
        check_frame(got_mem[checked], exp_q.pop_front(), "CMD frame");
        checked++;
      end
    end while (checked < issued || done_cnt < issued);
    repeat (8 * (MAX_DIV + 1)) @(negedge clk);
    check_count(frames_seen, issued, "frames on CMD");
    check_count(done_cnt, issued, "o_cmd_done pulses");
  endtask

  task automatic measure_clock(input logic [DIV_WIDTH-1:0] dmax);
    int hi;
    int lo;
    @(posedge clk);
    div_max <= dmax;
    repeat (4 * (MAX_DIV + 1)) @(negedge clk);  // let the old count run out
    do @(negedge clk); while (sd_clk);
    do @(negedge clk); while (!sd_clk);
    hi = 0;
    while (sd_clk) begin
      hi++;
      @(negedge clk);
    end
    lo = 0;
    while (!sd_clk) begin
      lo++;
      @(negedge clk);
    end
    check_period(hi, int'(dmax) + 1, "sd_clk high");
    check_period(lo, int'(dmax) + 1, "sd_clk low");
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_and_clock();
    @(negedge clk);
    check_level(sd_cmd_o, 1'b1, "o_sd_cmd after reset");
    check_level(busy, 1'b0, "o_busy after reset");
    check_level(cmd_done, 1'b0, "o_cmd_done after reset");
    measure_clock(8'd2);
    measure_clock(8'd5);
  endtask

  task automatic test_cmd0();
    check_frame(build_frame(6'd0, 32'd0), 48'h40_0000_0000_95, "reference CMD0");
    measure_clock(8'd3);
    issue_cmd('0, 48'h40_0000_0000_95);
    drain_frames();
  endtask

  task automatic test_random(input int n);
    sd_cmd_t c;
    repeat (n) begin
      c = rand_cmd();
      issue_cmd(c, build_frame(c.index, c.arg));
    end
    drain_frames();   // back to back when n exceeds the fifo depth
  endtask

  task automatic test_bypass();
    @(posedge clk);
    div_en <= 1'b0;
    repeat (8) begin
      @(posedge clk);
      #5 check_level(sd_clk, 1'b1, "bypass sd_clk high phase");
      @(negedge clk);
      check_level(sd_clk, 1'b0, "bypass sd_clk low phase");
    end
    test_random(2);
  endtask

  initial begin
    rst_n      = 1'b0;
    cmd_strobe = 1'b0;
    cmd_in     = '0;
    div_max    = 8'd2;
    div_en     = 1'b1;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_and_clock();
    test_cmd0();
    test_random(4);
    test_random(6);      // more than FIFO_DEPTH, framer stalls on full
    test_bypass();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- design/sd_cmd_host.sv
/*
  SD host command path, top level.
  Issue a command by pulsing i_cmd_strobe while o_busy is low.
  No responses, no DAT lines, no card init. CMD only, open loop.
  i_div_max is half the sd clock period minus one, in i_clk cycles.
*/

`timescale 1ns/1ps

module sd_cmd_host #(
  parameter int DIV_WIDTH  = 8,   // divide value width
  parameter int FIFO_DEPTH = 4    // frames queued, power of two
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,       // sync, active low
  input  logic                 i_cmd_strobe,  // one cycle, only when !o_busy
  input  sd_pkg::sd_cmd_t      i_cmd,
  input  logic [DIV_WIDTH-1:0] i_div_max,
  input  logic                 i_div_en,      // low = sd clock is i_clk
  output logic                 o_sd_clk,
  output logic                 o_sd_cmd,      // idles high
  output logic                 o_busy,
  output logic                 o_cmd_done     // pulse after each end bit
);

  import sd_pkg::*;

  logic      wr_en;       // framer -> fifo
  sd_frame_t wr_frame;
  logic      fifo_full;
  logic      rd_en;       // serializer -> fifo
  sd_frame_t rd_frame;
  logic      fifo_empty;
  logic      shift_tick;  // divider -> serializer

  ////////////////////////////////////////////////////////////////////
  // clock and producer / buffer / consumer chain
  ////////////////////////////////////////////////////////////////////

  sd_clk_divider #(
    .DIV_WIDTH (DIV_WIDTH)
  ) u_clk_div (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_div_max    (i_div_max),
    .i_div_en     (i_div_en),
    .o_sd_clk     (o_sd_clk),
    .o_shift_tick (shift_tick)
  );

  sd_cmd_framer u_framer (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_cmd_strobe (i_cmd_strobe),
    .i_cmd        (i_cmd),
    .i_fifo_full  (fifo_full),
    .o_busy       (o_busy),
    .o_wr_en      (wr_en),
    .o_wr_frame   (wr_frame)
  );

  sd_frame_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wr_en    (wr_en),
    .i_wr_frame (wr_frame),
    .i_rd_en    (rd_en),
    .o_rd_frame (rd_frame),
    .o_full     (fifo_full),
    .o_empty    (fifo_empty)
  );

  sd_cmd_serializer u_serializer (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_shift_tick (shift_tick),
    .i_fifo_empty (fifo_empty),
    .i_rd_frame   (rd_frame),
    .o_rd_en      (rd_en),
    .o_sd_cmd     (o_sd_cmd),
    .o_cmd_done   (o_cmd_done)
  );

endmodule

//--- design/sd_cmd_serializer.sv
/*
  CMD line serializer, the consumer side.
  Pops one frame whenever idle and the fifo has data, then drives one
  bit per shift tick, MSB first. The tick after the 48th bit returns
  CMD high and pulses o_cmd_done. Line rate follows the tick rate.
*/

`timescale 1ns/1ps

module sd_cmd_serializer (
  input  logic              i_clk,
  input  logic              i_rst_n,      // sync, active low
  input  logic              i_shift_tick, // from the divider, sd_clk fall
  input  logic              i_fifo_empty,
  input  sd_pkg::sd_frame_t i_rd_frame,   // fifo head
  output logic              o_rd_en,      // pop strobe
  output logic              o_sd_cmd,     // CMD line, idles high
  output logic              o_cmd_done    // one cycle after the end bit
);

  import sd_pkg::*;

  localparam int CNT_W = $clog2(SD_FRAME_BITS + 1);  // 0..48

  typedef logic [CNT_W-1:0] bit_cnt_t;

  sd_frame_t shift_q;   // remaining bits, msb is next out
  bit_cnt_t  bit_cnt;   // bits already driven
  logic      active;    // a frame is loaded
  logic      cmd_q;     // registered CMD level
  logic      done_q;
  logic      step;      // move one bit this cycle
  logic      last;      // all 48 bits are on the line

  assign o_rd_en = !active && !i_fifo_empty;    // pop and arm
  assign step    = active && i_shift_tick;
  assign last    = (bit_cnt == CNT_W'(SD_FRAME_BITS));

  ////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      active  <= 1'b0;
      bit_cnt <= '0;
      cmd_q   <= 1'b1;              // idle high
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;               // pulse by default low
      if (o_rd_en) begin
        active  <= 1'b1;            // first bit waits for the next tick
        bit_cnt <= '0;
      end else if (step) begin
        if (last) begin
          active <= 1'b0;
          cmd_q  <= 1'b1;           // end bit done, release the line
          done_q <= 1'b1;
        end else begin
          cmd_q   <= shift_q[SD_FRAME_BITS-1];
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // shift register
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (o_rd_en) begin
      shift_q <= i_rd_frame;
    end else if (step) begin
      shift_q <= {shift_q[SD_FRAME_BITS-2:0], 1'b1};  // fill with idle level
    end
  end

  assign o_sd_cmd   = cmd_q;
  assign o_cmd_done = done_q;

endmodule

//--- design/sd_frame_fifo.sv
/*
  Show-ahead frame buffer between framer and serializer.
  FIFO_DEPTH must be a power of two, 2 or more.
  No overflow or underflow guard. Writers must honor o_full and
  readers must honor o_empty.
*/

`timescale 1ns/1ps

module sd_frame_fifo #(
  parameter int FIFO_DEPTH = 4                // frames held
) (
  input  logic              i_clk,
  input  logic              i_rst_n,          // sync, active low
  input  logic              i_wr_en,          // push i_wr_frame
  input  sd_pkg::sd_frame_t i_wr_frame,
  input  logic              i_rd_en,          // pop the head entry
  output sd_pkg::sd_frame_t o_rd_frame,       // head entry, always visible
  output logic              o_full,
  output logic              o_empty
);

  import sd_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);      // pointer width
  localparam int CW = $clog2(FIFO_DEPTH + 1);  // occupancy 0..FIFO_DEPTH

  typedef logic [AW-1:0] ptr_t;
  typedef logic [CW-1:0] occ_t;

  sd_frame_t mem [FIFO_DEPTH];  // frame storage
  ptr_t      wr_ptr;
  ptr_t      rd_ptr;
  occ_t      occ;               // entries in use

  // storage, written on push
  always_ff @(posedge i_clk) begin
    if (i_wr_en) mem[wr_ptr] <= i_wr_frame;
  end

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      if (i_wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (i_rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({i_wr_en, i_rd_en})
        2'b10:   occ <= occ + 1'b1;   // push only
        2'b01:   occ <= occ - 1'b1;   // pop only
        default: occ <= occ;          // both or neither
      endcase
    end
  end

  assign o_rd_frame = mem[rd_ptr];            // show-ahead head
  assign o_full     = (occ == CW'(FIFO_DEPTH));
  assign o_empty    = (occ == '0);

endmodule

//--- design/sd_cmd_framer.sv
/*
  Command framer, the producer side of the CMD path.
  A strobe is taken in IDLE only. Strobes while o_busy is high are dropped.
  The CRC7 runs one bit per cycle over 40 bits, so a frame is ready
  41 cycles after the strobe. It waits in WRITE while the fifo is full.
*/

`timescale 1ns/1ps

module sd_cmd_framer (
  input  logic              i_clk,
  input  logic              i_rst_n,      // sync, active low
  input  logic              i_cmd_strobe, // one cycle pulse
  input  sd_pkg::sd_cmd_t   i_cmd,        // index + argument
  input  logic              i_fifo_full,  // back-pressure from the buffer
  output logic              o_busy,       // high while a command is held
  output logic              o_wr_en,      // write strobe into the fifo
  output sd_pkg::sd_frame_t o_wr_frame    // finished 48 bit frame
);

  import sd_pkg::*;

  localparam crc7_t CRC7_POLY = 7'h09;                // x^7 + x^3 + 1
  localparam int    CNT_W     = $clog2(SD_CRC_BITS);  // 0..39

  typedef logic [CNT_W-1:0] crc_cnt_t;

  framer_state_t          state;
  crc_cnt_t               bit_cnt;  // bits fed to the crc so far
  sd_cmd_t                cmd_q;    // latched command for frame assembly
  logic [SD_CRC_BITS-1:0] crc_sr;   // leading bits, shifted out msb first
  crc7_t                  crc_q;    // running remainder
  logic                   crc_fb;   // feedback into the polynomial taps
  logic                   take;     // strobe accepted this cycle

  assign take   = (state == IDLE) && i_cmd_strobe;
  assign crc_fb = crc_q[6] ^ crc_sr[SD_CRC_BITS-1];

  ////////////////////////////////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state   <= IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (i_cmd_strobe) begin
            state   <= CRC;
            bit_cnt <= '0;
          end
        end
        CRC: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_W'(SD_CRC_BITS - 1)) begin
            state <= WRITE;                    // last bit goes in this cycle
          end
        end
        WRITE: begin
          if (!i_fifo_full) state <= IDLE;     // write lands on this edge
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // serial crc7 datapath
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (take) begin
      cmd_q  <= i_cmd;
      crc_sr <= {2'b01, i_cmd};                // start 0, tx 1, index, arg
      crc_q  <= '0;
    end else if (state == CRC) begin
      crc_sr <= {crc_sr[SD_CRC_BITS-2:0], 1'b0};
      crc_q  <= {crc_q[5:0], 1'b0} ^ (crc_fb ? CRC7_POLY : crc7_t'(0));
    end
  end

  // frame assembly, end bit appended after the crc
  assign o_wr_frame = {2'b01, cmd_q, crc_q, 1'b1};
  assign o_wr_en    = (state == WRITE) && !i_fifo_full;
  assign o_busy     = (state != IDLE);

endmodule

//--- design/sd_clk_divider.sv
/*
  SD clock divider with a falling edge shift tick.
  Half period of o_sd_clk is i_div_max+1 cycles of i_clk.
  i_div_max is sampled at every reload, so a change takes effect after
  the current count expires. With i_div_en low the output is i_clk
  itself through a mux, so the card sees the raw system clock.
*/

`timescale 1ns/1ps

module sd_clk_divider #(
  parameter int DIV_WIDTH = 8             // width of the divide value
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,   // sync, active low
  input  logic [DIV_WIDTH-1:0] i_div_max, // half period minus one
  input  logic                 i_div_en,  // 0 = pass i_clk straight through
  output logic                 o_sd_clk,  // divided or bypassed clock
  output logic                 o_shift_tick // one cycle, at sd_clk fall
);

  typedef logic [DIV_WIDTH-1:0] div_cnt_t;

  div_cnt_t cnt_q;        // down counter
  logic     expire;       // count reached zero this cycle
  logic     reload;
  logic     toggle_q;     // divided clock before the bypass mux

  ////////////////////////////////////////////////////////////////////
  // reload counter
  ////////////////////////////////////////////////////////////////////

  assign expire = (cnt_q == '0);
  assign reload = !i_rst_n || expire;   // load on reset too, like a preset

  always_ff @(posedge i_clk) begin
    if (reload) begin
      cnt_q <= i_div_max;               // i_div_max+1 cycles until next expiry
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // toggle flop
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      toggle_q <= 1'b0;                 // clock starts low
    end else if (expire) begin
      toggle_q <= ~toggle_q;            // half period boundary
    end
  end

  // clock mux, bypass when division is off
  assign o_sd_clk = i_div_en ? toggle_q : i_clk;

  // expiry while high means the toggle is about to fall
  // in bypass every cycle carries one bit
  assign o_shift_tick = i_div_en ? (expire && toggle_q) : 1'b1;

endmodule

//--- design/sd_pkg.sv
/*
  Shared types for the SD command path.
  Frame layout is MSB first: start(0), tx(1), index, argument, crc7, end(1).
  The CRC covers the 40 leading bits only. The end bit is outside it.
*/

package sd_pkg;

  ////////////////////////////////////////////////////////////////////
  // frame geometry
  ////////////////////////////////////////////////////////////////////

  localparam int SD_FRAME_BITS = 48;  // full command token on CMD
  localparam int SD_CRC_BITS   = 40;  // start + tx + index + arg

  ////////////////////////////////////////////////////////////////////
  // field types
  ////////////////////////////////////////////////////////////////////

  typedef logic [5:0]               cmd_index_t;  // CMDn number
  typedef logic [31:0]              cmd_arg_t;    // command argument
  typedef logic [6:0]               crc7_t;       // x^7+x^3+1 remainder
  typedef logic [SD_FRAME_BITS-1:0] sd_frame_t;   // bit 47 leaves first

  // index and argument travel together from the user side
  typedef struct packed {
    cmd_index_t index;  // upper 6 bits
    cmd_arg_t   arg;    // lower 32 bits
  } sd_cmd_t;

  // framer control
  typedef enum logic [1:0] {
    IDLE,   // waiting for a strobe
    CRC,    // one bit of the crc per cycle
    WRITE   // frame ready, waiting on fifo space
  } framer_state_t;

endpackage
